/* filelist.f */
verilog/cpu_pkg.sv
verilog/memctrl.sv
verilog/fetcher.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/execute.sv
verilog/cpu.sv
tests/tb_clock.sv
tests/cpu_checker.sv
tests/tb_cpu.sv

/* run.sh */
#!/bin/sh
# build with verilator and run, pass only if the pass line appears
verilator --binary --timing --assert -f filelist.f --top-module tb_cpu -o tb_cpu_sim || exit 1
out=$(./obj_dir/tb_cpu_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED" && exit 0 || exit 1

/* tests/cpu_checker.sv */
// bus protocol assertions for the memory controller
`timescale 1ns/10ps
`default_nettype none

module cpu_checker (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        mem_wr,
    input wire logic [31:0] mem_a,
    input wire logic        io_buffer_full,
    input wire logic        if_req_en,
    input wire logic        dc_req_en,
    input wire logic        if_done,
    input wire logic        dc_done
);

    logic seen_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            seen_req <= 1'b0;
        end else if (if_req_en || dc_req_en) begin
            seen_req <= 1'b1;
        end
    end

    // no bus write before anyone has asked for one
    assert property (@(posedge clk) disable iff (reset)
        (!seen_req && !if_req_en && !dc_req_en) |-> !mem_wr)
        else $error("mem_wr high before the first request");

    assert property (@(posedge clk) disable iff (reset)
        (mem_wr && mem_a[17:16] == 2'b11) |-> !io_buffer_full)
        else $error("i/o write while io_buffer_full is high");

    assert property (@(posedge clk) disable iff (reset)
        !(if_done && dc_done))
        else $error("if_done and dc_done in the same cycle");

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
// testbench clock source, 40 ns period
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

endmodule

`default_nettype wire

/* tests/tb_cpu.sv */
// testbench for the rv32i core with a byte memory model and uart capture
// runs a small program and compares the printed bytes
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;

    localparam int n_rows = 66;
    localparam logic [8:0] no_byte = 9'h100;

    logic        clk;
    logic        reset;
    logic        rdy_in;
    logic [7:0]  mem_din;
    logic [7:0]  mem_dout;
    logic [31:0] mem_a;
    logic        mem_wr;
    logic        io_buffer_full;
    logic [31:0] dbgreg_dout;

    logic [7:0]  mem [0:131071];
    logic [31:0] prog_inst [n_rows];
    logic [8:0]  prog_exp [n_rows];
    int          row_cnt;
    logic [7:0]  got_q [$];
    logic [7:0]  exp_q [$];
    logic        stop_seen;
    int          full_hold;
    int unsigned seed_val;

    tb_clock u_clock (.clk(clk));

    cpu u_cpu (
        .clk_in         (clk),
        .reset          (reset),
        .rdy_in         (rdy_in),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .io_buffer_full (io_buffer_full),
        .dbgreg_dout    (dbgreg_dout)
    );

    bind memctrl cpu_checker u_cpu_checker (
        .clk            (clk),
        .reset          (reset),
        .mem_wr         (mem_wr),
        .mem_a          (mem_a),
        .io_buffer_full (io_buffer_full),
        .if_req_en      (if_req_en),
        .dc_req_en      (dc_req_en),
        .if_done        (if_done),
        .dc_done        (dc_done)
    );

    // instruction encoders
    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], cpu_pkg::op_reg};
    endfunction

    function automatic logic [31:0] enc_i(logic [6:0] op, int rd, int f3, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(int f3, int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], cpu_pkg::op_store};
    endfunction

    function automatic logic [31:0] enc_b(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                cpu_pkg::op_branch};
    endfunction

    function automatic logic [31:0] enc_u(logic [6:0] op, int rd, int imm20);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_j(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], cpu_pkg::op_jal};
    endfunction

    task automatic add_row(logic [31:0] inst, logic [8:0] exp);
        prog_inst[row_cnt] = inst;
        prog_exp[row_cnt]  = exp;
        row_cnt++;
    endtask

    // program rows with the byte each one prints
    // x31 holds the uart address
    task automatic build_table;
        row_cnt = 0;
        add_row(enc_u(cpu_pkg::op_lui, 31, 32'h30), no_byte);
        add_row(enc_i(cpu_pkg::op_imm, 1, 0, 0, 32'h55), no_byte);
        add_row(enc_s(0, 1, 31, 0), 9'h55);
        add_row(enc_i(cpu_pkg::op_imm, 2, 0, 0, -3), no_byte);
        add_row(enc_r(0, 2, 1, 0, 3), no_byte);
        add_row(enc_s(0, 3, 31, 0), 9'h52);
        add_row(enc_r(32, 2, 1, 0, 4), no_byte);
        add_row(enc_s(0, 4, 31, 0), 9'h58);
        add_row(enc_i(cpu_pkg::op_imm, 5, 4, 1, 32'h0f), no_byte);
        add_row(enc_s(0, 5, 31, 0), 9'h5a);
        add_row(enc_i(cpu_pkg::op_imm, 6, 1, 1, 4), no_byte);
        add_row(enc_s(0, 6, 31, 0), 9'h50);
        add_row(enc_i(cpu_pkg::op_imm, 7, 5, 2, 32'h401), no_byte);
        add_row(enc_s(0, 7, 31, 0), 9'hfe);
        add_row(enc_i(cpu_pkg::op_imm, 8, 5, 2, 28), no_byte);
        add_row(enc_s(0, 8, 31, 0), 9'h0f);
        add_row(enc_r(0, 1, 2, 2, 9), no_byte);
        add_row(enc_s(0, 9, 31, 0), 9'h01);
        add_row(enc_r(0, 1, 2, 3, 10), no_byte);
        add_row(enc_s(0, 10, 31, 0), 9'h00);
        add_row(enc_r(0, 2, 1, 6, 11), no_byte);
        add_row(enc_s(0, 11, 31, 0), 9'hfd);
        add_row(enc_u(cpu_pkg::op_auipc, 12, 1), no_byte);
        add_row(enc_s(0, 12, 31, 0), 9'h58);
        // a taken branch skips the print after it
        add_row(enc_b(0, 1, 1, 8), no_byte);
        add_row(enc_s(0, 1, 31, 0), no_byte);
        add_row(enc_b(1, 1, 1, 8), no_byte);
        add_row(enc_s(0, 9, 31, 0), 9'h01);
        add_row(enc_b(4, 2, 1, 8), no_byte);
        add_row(enc_s(0, 1, 31, 0), no_byte);
        add_row(enc_b(5, 2, 1, 8), no_byte);
        add_row(enc_s(0, 3, 31, 0), 9'h52);
        add_row(enc_b(6, 2, 1, 8), no_byte);
        add_row(enc_s(0, 4, 31, 0), 9'h58);
        add_row(enc_b(7, 2, 1, 8), no_byte);
        add_row(enc_s(0, 1, 31, 0), no_byte);
        add_row(enc_j(13, 8), no_byte);
        add_row(enc_s(0, 1, 31, 0), no_byte);
        add_row(enc_s(0, 13, 31, 0), 9'h94);
        add_row(enc_i(cpu_pkg::op_jalr, 14, 0, 13, 16), no_byte);
        add_row(enc_s(0, 1, 31, 0), no_byte);
        add_row(enc_s(0, 14, 31, 0), 9'ha0);
        // loads and stores around 0x1000
        add_row(enc_u(cpu_pkg::op_lui, 15, 1), no_byte);
        add_row(enc_u(cpu_pkg::op_lui, 16, 32'h87654), no_byte);
        add_row(enc_i(cpu_pkg::op_imm, 16, 0, 16, 32'h321), no_byte);
        add_row(enc_s(2, 16, 15, 0), no_byte);
        add_row(enc_i(cpu_pkg::op_load, 17, 0, 15, 3), no_byte);
        add_row(enc_i(cpu_pkg::op_imm, 18, 5, 17, 8), no_byte);
        add_row(enc_s(0, 18, 31, 0), 9'hff);
        add_row(enc_i(cpu_pkg::op_load, 19, 4, 15, 3), no_byte);
        add_row(enc_i(cpu_pkg::op_imm, 20, 5, 19, 4), no_byte);
        add_row(enc_s(0, 20, 31, 0), 9'h08);
        add_row(enc_i(cpu_pkg::op_load, 21, 1, 15, 2), no_byte);
        add_row(enc_i(cpu_pkg::op_imm, 22, 5, 21, 32'h40c), no_byte);
        add_row(enc_s(0, 22, 31, 0), 9'hf8);
        add_row(enc_i(cpu_pkg::op_load, 23, 5, 15, 2), no_byte);
        add_row(enc_i(cpu_pkg::op_imm, 24, 5, 23, 8), no_byte);
        add_row(enc_s(0, 24, 31, 0), 9'h87);
        add_row(enc_s(0, 1, 15, 1), no_byte);
        add_row(enc_s(1, 2, 15, 2), no_byte);
        add_row(enc_i(cpu_pkg::op_load, 25, 2, 15, 0), no_byte);
        add_row(enc_i(cpu_pkg::op_imm, 26, 5, 25, 8), no_byte);
        add_row(enc_s(0, 26, 31, 0), 9'h55);
        add_row(enc_i(cpu_pkg::op_imm, 27, 5, 25, 16), no_byte);
        add_row(enc_s(0, 27, 31, 0), 9'hfd);
        add_row(enc_s(0, 0, 31, 4), no_byte);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // byte memory with one cycle read latency
    always @(posedge clk) begin
        mem_din <= mem[mem_a[16:0]];
        if (mem_wr) begin
            if (mem_a == cpu_pkg::io_base) begin
                got_q.push_back(mem_dout);
            end else if (mem_a == cpu_pkg::io_stop_addr) begin
                stop_seen <= 1'b1;
            end else if (mem_a[17:16] != 2'b11) begin
                mem[mem_a[16:0]] = mem_dout;
            end
        end
    end

    // random pauses and uart back-pressure bursts
    always @(posedge clk) begin
        if (!reset) begin
            rdy_in <= ($urandom % 4) != 0;
            if (full_hold != 0) begin
                io_buffer_full <= 1'b1;
                full_hold      <= full_hold - 1;
            end else begin
                io_buffer_full <= ($urandom % 4) == 0;
                if ($urandom % 12 == 0)
                    full_hold <= 8;
            end
        end
    end

    initial begin
        logic [16:0] addr;
        logic [31:0] word;
        seed_val       = $urandom(32'hab9fdbfa);
        reset          = 1'b1;
        rdy_in         = 1'b1;
        io_buffer_full = 1'b0;
        mem_din        = 8'h00;
        stop_seen      = 1'b0;
        full_hold      = 0;
        for (int a = 0; a < 131072; a++) begin
            addr      = 17'(a);
            mem[addr] = addr[7:0] ^ addr[15:8] ^ {7'b0, addr[16]};
        end
        build_table();
        for (int i = 0; i < n_rows; i++) begin
            word = prog_inst[i];
            for (int k = 0; k < 4; k++) begin
                addr      = 17'(4 * i + k);
                mem[addr] = word[8*k +: 8];
            end
            if (!prog_exp[i][8])
                exp_q.push_back(prog_exp[i][7:0]);
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        while (!stop_seen) @(posedge clk);
        check_value("uart_count", 32'(got_q.size()), 32'(exp_q.size()));
        foreach (exp_q[i]) begin
            check_value("uart_byte", {24'b0, got_q[i]}, {24'b0, exp_q[i]});
        end
        // x27 is the last register written
        check_value("dbgreg_dout", dbgreg_dout, 32'h0000fffd);
        $display("Simulation PASSED");
        $finish;
    end

    // watchdog allows 40 cycles per row and four times that for pauses
    initial begin
        repeat (n_rows * 40 * 4 + 10) @(posedge clk);
        $display("Timeout, program did not reach stop");
        $display("Simulation FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* verilog/cpu.sv */
// rv32i core top level, one instruction in flight
// fetch, decode, execute and write-back around a byte-wide memory bus
`timescale 1ns/10ps
`default_nettype none

module cpu (
    input  logic        clk_in,
    input  logic        reset,
    input  logic        rdy_in,
    input  logic [7:0]  mem_din,
    output logic [7:0]  mem_dout,
    output logic [31:0] mem_a,
    output logic        mem_wr,
    input  logic        io_buffer_full,
    output logic [31:0] dbgreg_dout
);

    // fetch side
    logic                if_req_en;
    cpu_pkg::mem_req_t   if_req;
    logic                if_done;
    cpu_pkg::xlen_t      if_rdata;
    logic                fetch_valid;
    cpu_pkg::fetch_pkt_t fetch_pkt;

    // decode and register file
    cpu_pkg::reg_idx_t   rs1_idx;
    cpu_pkg::reg_idx_t   rs2_idx;
    cpu_pkg::xlen_t      rs1_data;
    cpu_pkg::xlen_t      rs2_data;
    logic                issue_valid;
    cpu_pkg::issue_pkt_t issue_pkt;

    // execute side
    logic                dc_req_en;
    cpu_pkg::mem_req_t   dc_req;
    logic                dc_done;
    cpu_pkg::xlen_t      dc_rdata;
    cpu_pkg::wb_t        wb;
    logic                exec_done;
    cpu_pkg::xlen_t      next_pc;

    memctrl u_memctrl (
        .clk            (clk_in),
        .reset          (reset),
        .rdy            (rdy_in),
        .io_buffer_full (io_buffer_full),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .if_req_en      (if_req_en),
        .if_req         (if_req),
        .if_done        (if_done),
        .if_rdata       (if_rdata),
        .dc_req_en      (dc_req_en),
        .dc_req         (dc_req),
        .dc_done        (dc_done),
        .dc_rdata       (dc_rdata)
    );

    fetcher u_fetcher (
        .clk         (clk_in),
        .reset       (reset),
        .rdy         (rdy_in),
        .exec_done   (exec_done),
        .next_pc     (next_pc),
        .if_req_en   (if_req_en),
        .if_req      (if_req),
        .if_done     (if_done),
        .if_rdata    (if_rdata),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt)
    );

    decoder u_decoder (
        .clk         (clk_in),
        .reset       (reset),
        .rdy         (rdy_in),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt)
    );

    regfile u_regfile (
        .clk         (clk_in),
        .reset       (reset),
        .rdy         (rdy_in),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb          (wb),
        .dbgreg_dout (dbgreg_dout)
    );

    execute u_execute (
        .clk         (clk_in),
        .reset       (reset),
        .rdy         (rdy_in),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .dc_req_en   (dc_req_en),
        .dc_req      (dc_req),
        .dc_done     (dc_done),
        .dc_rdata    (dc_rdata),
        .wb          (wb),
        .exec_done   (exec_done),
        .next_pc     (next_pc)
    );

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
// shared types and constants for the in-order rv32i core
// opcodes, stage packets and the memory map
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // 128 KB ram below, i/o where addr[17:16] == 2'b11
    localparam xlen_t io_base      = 32'h0003_0000;
    localparam xlen_t io_stop_addr = 32'h0003_0004;

    // transfer length, stored as byte count minus one
    localparam logic [1:0] len_b = 2'd0;
    localparam logic [1:0] len_h = 2'd1;
    localparam logic [1:0] len_w = 2'd3;

    typedef struct packed {
        xlen_t pc;
        xlen_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        xlen_t      pc;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic       funct7_5;
        reg_idx_t   rd;
        xlen_t      imm;
        xlen_t      rs1_val;
        xlen_t      rs2_val;
    } issue_pkt_t;

    typedef struct packed {
        xlen_t      addr;
        xlen_t      wdata;
        logic [1:0] len;
        logic       write;
    } mem_req_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

endpackage

`default_nettype wire

/* verilog/decoder.sv */
// instruction decode, builds the immediate and registers the operands
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  logic                clk,
    input  logic                reset,
    input  logic                rdy,
    input  logic                fetch_valid,
    input  cpu_pkg::fetch_pkt_t fetch_pkt,
    output cpu_pkg::reg_idx_t   rs1_idx,
    output cpu_pkg::reg_idx_t   rs2_idx,
    input  cpu_pkg::xlen_t      rs1_data,
    input  cpu_pkg::xlen_t      rs2_data,
    output logic                issue_valid,
    output cpu_pkg::issue_pkt_t issue_pkt
);

    cpu_pkg::xlen_t inst;
    logic [6:0]     opcode;
    cpu_pkg::xlen_t imm;

    assign inst    = fetch_pkt.inst;
    assign opcode  = inst[6:0];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];

    // immediate format follows the opcode
    always_comb begin
        case (opcode)
            cpu_pkg::op_lui,
            cpu_pkg::op_auipc:
                imm = {inst[31:12], 12'b0};
            cpu_pkg::op_jal:
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            cpu_pkg::op_branch:
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            cpu_pkg::op_store:
                imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            default:
                imm = {{21{inst[31]}}, inst[30:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else if (rdy) begin
            issue_valid <= fetch_valid;
            if (fetch_valid) begin
                issue_pkt.pc       <= fetch_pkt.pc;
                issue_pkt.opcode   <= opcode;
                issue_pkt.funct3   <= inst[14:12];
                issue_pkt.funct7_5 <= inst[30];
                issue_pkt.rd       <= inst[11:7];
                issue_pkt.imm      <= imm;
                issue_pkt.rs1_val  <= rs1_data;
                issue_pkt.rs2_val  <= rs2_data;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/execute.sv */
// execute stage, alu and branches, loads and stores, write-back and next pc
`timescale 1ns/10ps
`default_nettype none

module execute (
    input  logic                clk,
    input  logic                reset,
    input  logic                rdy,
    input  logic                issue_valid,
    input  cpu_pkg::issue_pkt_t issue_pkt,
    output logic                dc_req_en,
    output cpu_pkg::mem_req_t   dc_req,
    input  logic                dc_done,
    input  cpu_pkg::xlen_t      dc_rdata,
    output cpu_pkg::wb_t        wb,
    output logic                exec_done,
    output cpu_pkg::xlen_t      next_pc
);

    typedef enum logic {
        s_idle,
        s_mem
    } state_t;

    state_t         state;
    logic           is_reg;
    logic           is_mem;
    cpu_pkg::xlen_t opb;
    cpu_pkg::xlen_t ea;
    cpu_pkg::xlen_t pc_plus4;
    cpu_pkg::xlen_t alu;
    cpu_pkg::xlen_t result;
    cpu_pkg::xlen_t npc;
    cpu_pkg::xlen_t load_val;
    logic [1:0]     len;
    logic           taken;

    assign is_reg   = issue_pkt.opcode == cpu_pkg::op_reg;
    assign is_mem   = issue_pkt.opcode == cpu_pkg::op_load
                    || issue_pkt.opcode == cpu_pkg::op_store;
    assign opb      = is_reg ? issue_pkt.rs2_val : issue_pkt.imm;
    assign ea       = issue_pkt.rs1_val + issue_pkt.imm;
    assign pc_plus4 = issue_pkt.pc + 32'd4;

    always_comb begin
        case (issue_pkt.funct3)
            3'd0: alu = (is_reg && issue_pkt.funct7_5) ? issue_pkt.rs1_val - opb
                                                       : issue_pkt.rs1_val + opb;
            3'd1: alu = issue_pkt.rs1_val << opb[4:0];
            3'd2: alu = {31'b0, $signed(issue_pkt.rs1_val) < $signed(opb)};
            3'd3: alu = {31'b0, issue_pkt.rs1_val < opb};
            3'd4: alu = issue_pkt.rs1_val ^ opb;
            3'd5: alu = issue_pkt.funct7_5 ? $signed(issue_pkt.rs1_val) >>> opb[4:0]
                                           : issue_pkt.rs1_val >> opb[4:0];
            3'd6: alu = issue_pkt.rs1_val | opb;
            default: alu = issue_pkt.rs1_val & opb;
        endcase
    end

    // the six branch compares
    always_comb begin
        case (issue_pkt.funct3)
            3'd0: taken = issue_pkt.rs1_val == issue_pkt.rs2_val;
            3'd1: taken = issue_pkt.rs1_val != issue_pkt.rs2_val;
            3'd4: taken = $signed(issue_pkt.rs1_val) < $signed(issue_pkt.rs2_val);
            3'd5: taken = $signed(issue_pkt.rs1_val) >= $signed(issue_pkt.rs2_val);
            3'd6: taken = issue_pkt.rs1_val < issue_pkt.rs2_val;
            3'd7: taken = issue_pkt.rs1_val >= issue_pkt.rs2_val;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        npc    = pc_plus4;
        result = alu;
        case (issue_pkt.opcode)
            cpu_pkg::op_lui:    result = issue_pkt.imm;
            cpu_pkg::op_auipc:  result = issue_pkt.pc + issue_pkt.imm;
            cpu_pkg::op_jal: begin
                result = pc_plus4;
                npc    = issue_pkt.pc + issue_pkt.imm;
            end
            cpu_pkg::op_jalr: begin
                result = pc_plus4;
                npc    = ea & ~32'd1;
            end
            cpu_pkg::op_branch: if (taken) npc = issue_pkt.pc + issue_pkt.imm;
            default: ;
        endcase
    end

    // load data extension by funct3
    always_comb begin
        case (issue_pkt.funct3)
            3'd0: load_val = {{24{dc_rdata[7]}}, dc_rdata[7:0]};
            3'd1: load_val = {{16{dc_rdata[15]}}, dc_rdata[15:0]};
            3'd4: load_val = {24'b0, dc_rdata[7:0]};
            3'd5: load_val = {16'b0, dc_rdata[15:0]};
            default: load_val = dc_rdata;
        endcase
    end

    assign len = (issue_pkt.funct3[1:0] == 2'd0) ? cpu_pkg::len_b
               : (issue_pkt.funct3[1:0] == 2'd1) ? cpu_pkg::len_h : cpu_pkg::len_w;

    // issue packet stays put until the next fetch, so the request is combinational
    assign dc_req = '{addr: ea, wdata: issue_pkt.rs2_val, len: len,
                      write: issue_pkt.opcode == cpu_pkg::op_store};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= s_idle;
            dc_req_en <= 1'b0;
            exec_done <= 1'b0;
            wb        <= '0;
        end else if (rdy) begin
            dc_req_en <= 1'b0;
            exec_done <= 1'b0;
            wb.en     <= 1'b0;
            if (state == s_idle && issue_valid) begin
                if (is_mem) begin
                    dc_req_en <= 1'b1;
                    state     <= s_mem;
                end else begin
                    exec_done <= 1'b1;
                    next_pc   <= npc;
                    wb        <= '{en: issue_pkt.opcode != cpu_pkg::op_branch,
                                   rd: issue_pkt.rd, data: result};
                end
            end else if (state == s_mem && dc_done) begin
                exec_done <= 1'b1;
                next_pc   <= npc;
                wb        <= '{en: issue_pkt.opcode == cpu_pkg::op_load,
                               rd: issue_pkt.rd, data: load_val};
                state     <= s_idle;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fetcher.sv */
// instruction fetch, one word per instruction
`timescale 1ns/10ps
`default_nettype none

module fetcher (
    input  logic                clk,
    input  logic                reset,
    input  logic                rdy,
    input  logic                exec_done,
    input  cpu_pkg::xlen_t      next_pc,
    output logic                if_req_en,
    output cpu_pkg::mem_req_t   if_req,
    input  logic                if_done,
    input  cpu_pkg::xlen_t      if_rdata,
    output logic                fetch_valid,
    output cpu_pkg::fetch_pkt_t fetch_pkt
);

    typedef enum logic [1:0] {
        s_boot,
        s_mem,
        s_exec
    } state_t;

    state_t         state;
    cpu_pkg::xlen_t pc;

    assign if_req = '{addr: pc, wdata: '0, len: cpu_pkg::len_w, write: 1'b0};

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= s_boot;
            pc          <= '0;
            if_req_en   <= 1'b0;
            fetch_valid <= 1'b0;
        end else if (rdy) begin
            if_req_en   <= 1'b0;
            fetch_valid <= 1'b0;
            case (state)
                s_boot: begin
                    if_req_en <= 1'b1;
                    state     <= s_mem;
                end
                s_mem: if (if_done) begin
                    fetch_valid <= 1'b1;
                    fetch_pkt   <= '{pc: pc, inst: if_rdata};
                    state       <= s_exec;
                end
                default: if (exec_done) begin
                    // wait here until execute retires the instruction
                    pc        <= next_pc;
                    if_req_en <= 1'b1;
                    state     <= s_mem;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/memctrl.sv */
// memory controller, serves fetch and data word requests over the byte bus
// data port wins when both ask in the same cycle
`timescale 1ns/10ps
`default_nettype none

module memctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              rdy,
    input  logic              io_buffer_full,
    input  logic [7:0]        mem_din,
    output logic [7:0]        mem_dout,
    output logic [31:0]       mem_a,
    output logic              mem_wr,
    input  logic              if_req_en,
    input  cpu_pkg::mem_req_t if_req,
    output logic              if_done,
    output cpu_pkg::xlen_t    if_rdata,
    input  logic              dc_req_en,
    input  cpu_pkg::mem_req_t dc_req,
    output logic              dc_done,
    output cpu_pkg::xlen_t    dc_rdata
);

    logic              busy;
    logic              cur_dc;
    cpu_pkg::mem_req_t cur;
    logic              if_pend;
    cpu_pkg::mem_req_t pend_req;
    logic [1:0]        cnt;
    logic              issued;
    cpu_pkg::xlen_t    rdata;

    logic              go;
    logic              act_dc;
    cpu_pkg::mem_req_t act;
    logic              is_io;
    logic              io_hold;
    logic              last;
    logic [1:0]        idx;

    // request in progress, or the one starting this cycle
    always_comb begin
        go     = busy;
        act_dc = cur_dc;
        act    = cur;
        if (!busy) begin
            go     = dc_req_en | if_pend | if_req_en;
            act_dc = dc_req_en;
            if (dc_req_en)
                act = dc_req;
            else if (if_pend)
                act = pend_req;
            else
                act = if_req;
        end
    end

    assign is_io   = (act.addr & cpu_pkg::io_base) == cpu_pkg::io_base;
    assign io_hold = act.write & is_io & io_buffer_full;
    assign last    = cnt == act.len;

    // a read in its capture cycle already puts out the next byte,
    // on a paused cycle the current byte goes out again
    assign idx = cnt + {1'b0, issued & rdy & ~last};

    assign mem_a    = go ? act.addr + {30'b0, idx} : '0;
    assign mem_dout = act.wdata[8*cnt +: 8];
    assign mem_wr   = go & act.write & rdy & ~io_hold;

    assign if_rdata = rdata;
    assign dc_rdata = rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            cur_dc  <= 1'b0;
            if_pend <= 1'b0;
            cnt     <= 2'd0;
            issued  <= 1'b0;
            if_done <= 1'b0;
            dc_done <= 1'b0;
        end else if (rdy) begin
            if_done <= 1'b0;
            dc_done <= 1'b0;
            if (if_req_en && (busy || dc_req_en)) begin
                if_pend  <= 1'b1;
                pend_req <= if_req;
            end else if (!busy && !dc_req_en) begin
                if_pend <= 1'b0;
            end
            if (go) begin
                busy   <= 1'b1;
                cur    <= act;
                cur_dc <= act_dc;
                if (act.write) begin
                    if (!io_hold) begin
                        cnt <= cnt + 2'd1;
                        if (last) begin
                            busy    <= 1'b0;
                            cnt     <= 2'd0;
                            dc_done <= act_dc;
                            if_done <= ~act_dc;
                        end
                    end
                end else if (!issued) begin
                    issued <= 1'b1;
                end else begin
                    // little-endian assembly
                    rdata[8*cnt +: 8] <= mem_din;
                    cnt               <= cnt + 2'd1;
                    if (last) begin
                        busy    <= 1'b0;
                        cnt     <= 2'd0;
                        issued  <= 1'b0;
                        dc_done <= act_dc;
                        if_done <= ~act_dc;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
// register file, two combinational reads and one write
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  logic              clk,
    input  logic              reset,
    input  logic              rdy,
    input  cpu_pkg::reg_idx_t rs1_idx,
    input  cpu_pkg::reg_idx_t rs2_idx,
    output cpu_pkg::xlen_t    rs1_data,
    output cpu_pkg::xlen_t    rs2_data,
    input  cpu_pkg::wb_t      wb,
    output cpu_pkg::xlen_t    dbgreg_dout
);

    cpu_pkg::xlen_t regs [32];

    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            dbgreg_dout <= '0;
        end else if (rdy && wb.en && wb.rd != 5'd0) begin
            // x0 writes never land
            regs[wb.rd] <= wb.data;
            dbgreg_dout <= wb.data;
        end
    end

endmodule

`default_nettype wire
